// File: source/fpu_macros.svh
// FP64 widths only; changing FPU_WIDTH needs matching exponent and mantissa widths
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH
`default_nettype none

`define FPU_WIDTH        64
`define FPU_EXP_WIDTH    11
`define FPU_MAN_WIDTH    52
`define FPU_TAG_WIDTH    6
`define FPU_STATUS_WIDTH 5
`define FPU_CLASS_WIDTH  6

// Sign 0, exponent all ones, quiet bit set
`define FPU_CANON_NAN    64'h7ff8000000000000

`default_nettype wire
`endif

// File: source/fpu_pkg.sv
// FP64 non-arithmetic FPU types; the rounding mode only selects an operation variant
`default_nettype none

package fpu_pkg;

  typedef enum logic [1:0] {
    SGNJ     = 2'd0,
    MINMAX   = 2'd1,
    CMP      = 2'd2,
    CLASSIFY = 2'd3
  } fpu_op_e;

  // SGNJ: RNE plain, RTZ negated, RDN xor; MINMAX: RNE min, RTZ max
  // CMP: RNE le, RTZ lt, RDN eq
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } roundmode_e;

  localparam int unsigned STATUS_NV = 4;  // Invalid operation
  localparam int unsigned STATUS_DZ = 3;
  localparam int unsigned STATUS_OF = 2;
  localparam int unsigned STATUS_UF = 1;
  localparam int unsigned STATUS_NX = 0;

  localparam int unsigned CLASS_NAN    = 5;  // Per-operand class vector
  localparam int unsigned CLASS_SNAN   = 4;
  localparam int unsigned CLASS_INF    = 3;
  localparam int unsigned CLASS_ZERO   = 2;
  localparam int unsigned CLASS_SUB    = 1;
  localparam int unsigned CLASS_NORMAL = 0;

endpackage

`default_nettype wire

// File: source/spill_register.sv
// Two-entry valid/ready slice with no bypass; a sender must hold data_i while valid_i waits
`timescale 1ns/1ns
`default_nettype none

module spill_register #(
  parameter int unsigned WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  logic             head_full_q, spill_full_q;
  logic [WIDTH-1:0] head_data_q, spill_data_q;
  logic             push, pop;
  logic             head_load, spill_load;

  assign ready_o = ~spill_full_q;  // Registered state only
  assign valid_o = head_full_q;
  assign data_o  = head_data_q;

  assign push       = valid_i & ready_o;
  assign pop        = head_full_q & ready_i;
  assign head_load  = pop ? (spill_full_q | push) : (push & ~head_full_q);
  assign spill_load = push & head_full_q & ~pop;  // Head stalled

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      head_full_q  <= 1'b0;
      spill_full_q <= 1'b0;
    end else begin
      if (pop) begin
        head_full_q <= spill_full_q | push;
      end else begin
        head_full_q <= head_full_q | push;
      end
      spill_full_q <= ~pop & (spill_full_q | spill_load);
    end
  end

  always_ff @(posedge clk_i) begin
    if (head_load) begin
      head_data_q <= spill_full_q ? spill_data_q : data_i;  // Oldest word first
    end
    if (spill_load) begin
      spill_data_q <= data_i;
    end
  end

  a_hold_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

  a_spill_no_overwrite: assert property (@(posedge clk_i) disable iff (reset_i)
    spill_full_q |=> $stable(spill_data_q));

endmodule

`default_nettype wire

// File: source/fp_classify_stage.sv
// FP64 operand decode stage, one registered entry; sign is left in bit 63 of each operand
`timescale 1ns/1ns
`include "fpu_macros.svh"
`default_nettype none

module fp_classify_stage import fpu_pkg::*; (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        valid_i,
  output logic                        ready_o,
  input  logic [`FPU_WIDTH-1:0]       op_a_i,
  input  logic [`FPU_WIDTH-1:0]       op_b_i,
  input  fpu_op_e                     op_i,
  input  roundmode_e                  rnd_mode_i,
  input  logic [`FPU_TAG_WIDTH-1:0]   tag_i,
  output logic                        valid_o,
  input  logic                        ready_i,
  output logic [`FPU_WIDTH-1:0]       op_a_o,
  output logic [`FPU_WIDTH-1:0]       op_b_o,
  output fpu_op_e                     op_o,
  output roundmode_e                  rnd_mode_o,
  output logic [`FPU_TAG_WIDTH-1:0]   tag_o,
  output logic [`FPU_CLASS_WIDTH-1:0] a_class_o,
  output logic [`FPU_CLASS_WIDTH-1:0] b_class_o
);

  function automatic logic [`FPU_CLASS_WIDTH-1:0] decode_class(
    input logic [`FPU_WIDTH-1:0] op
  );
    logic [`FPU_EXP_WIDTH-1:0]   exponent;
    logic [`FPU_MAN_WIDTH-1:0]   mantissa;
    logic                        exp_ones, exp_zero, man_zero;
    logic [`FPU_CLASS_WIDTH-1:0] cls;
    exponent = op[`FPU_WIDTH-2 -: `FPU_EXP_WIDTH];
    mantissa = op[`FPU_MAN_WIDTH-1:0];
    exp_ones = &exponent;
    exp_zero = ~|exponent;
    man_zero = ~|mantissa;
    cls                = '0;
    cls[CLASS_NAN]     = exp_ones & ~man_zero;
    cls[CLASS_SNAN]    = exp_ones & ~man_zero & ~mantissa[`FPU_MAN_WIDTH-1];  // Quiet bit clear
    cls[CLASS_INF]     = exp_ones & man_zero;
    cls[CLASS_ZERO]    = exp_zero & man_zero;
    cls[CLASS_SUB]     = exp_zero & ~man_zero;
    cls[CLASS_NORMAL]  = ~exp_ones & ~exp_zero;
    return cls;
  endfunction

  logic valid_q;
  logic load;

  assign ready_o = ~valid_q | ready_i;
  assign valid_o = valid_q;
  assign load    = valid_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      op_a_o     <= op_a_i;
      op_b_o     <= op_b_i;
      op_o       <= op_i;
      rnd_mode_o <= rnd_mode_i;
      tag_o      <= tag_i;
      a_class_o  <= decode_class(op_a_i);
      b_class_o  <= decode_class(op_b_i);
    end
  end

  a_class_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o |-> $onehot({a_class_o[CLASS_NAN], a_class_o[CLASS_INF], a_class_o[CLASS_ZERO],
                         a_class_o[CLASS_SUB], a_class_o[CLASS_NORMAL]})
             && $onehot({b_class_o[CLASS_NAN], b_class_o[CLASS_INF], b_class_o[CLASS_ZERO],
                         b_class_o[CLASS_SUB], b_class_o[CLASS_NORMAL]}));

endmodule

`default_nettype wire

// File: source/fp_noncomp_stage.sv
// FP64 sign injection, min/max, compare and classify; only NV can be raised
`timescale 1ns/1ns
`include "fpu_macros.svh"
`default_nettype none

module fp_noncomp_stage import fpu_pkg::*; (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         valid_i,
  output logic                         ready_o,
  input  logic [`FPU_WIDTH-1:0]        op_a_i,
  input  logic [`FPU_WIDTH-1:0]        op_b_i,
  input  fpu_op_e                      op_i,
  input  roundmode_e                   rnd_mode_i,
  input  logic [`FPU_TAG_WIDTH-1:0]    tag_i,
  input  logic [`FPU_CLASS_WIDTH-1:0]  a_class_i,
  input  logic [`FPU_CLASS_WIDTH-1:0]  b_class_i,
  output logic                         valid_o,
  input  logic                         ready_i,
  output logic [`FPU_WIDTH-1:0]        result_o,
  output logic [`FPU_STATUS_WIDTH-1:0] status_o,
  output logic [`FPU_TAG_WIDTH-1:0]    tag_o
);

  logic sign_a, sign_b, inj_sign;
  logic mag_lt, mag_eq, a_lt_b, both_zero;
  logic any_nan, any_snan, cmp_bit;
  logic [9:0] class_mask;
  logic [`FPU_WIDTH-1:0] result_d;
  logic [`FPU_STATUS_WIDTH-1:0] status_d;
  logic nv_d;
  logic valid_q, load;

  assign sign_a    = op_a_i[`FPU_WIDTH-1];
  assign sign_b    = op_b_i[`FPU_WIDTH-1];
  assign mag_lt    = op_a_i[`FPU_WIDTH-2:0] < op_b_i[`FPU_WIDTH-2:0];
  assign mag_eq    = op_a_i[`FPU_WIDTH-2:0] == op_b_i[`FPU_WIDTH-2:0];
  assign a_lt_b    = (sign_a != sign_b) ? sign_a : (sign_a ? ~(mag_lt | mag_eq) : mag_lt);
  assign both_zero = a_class_i[CLASS_ZERO] & b_class_i[CLASS_ZERO];
  assign any_nan   = a_class_i[CLASS_NAN] | b_class_i[CLASS_NAN];
  assign any_snan  = a_class_i[CLASS_SNAN] | b_class_i[CLASS_SNAN];

  always_comb begin
    case (rnd_mode_i)
      RTZ:     inj_sign = ~sign_b;
      RDN:     inj_sign = sign_a ^ sign_b;
      default: inj_sign = sign_b;
    endcase
  end

  always_comb begin
    case (rnd_mode_i)
      RNE:     cmp_bit = (a_lt_b & ~both_zero) | mag_eq & (sign_a == sign_b) | both_zero;
      RTZ:     cmp_bit = a_lt_b & ~both_zero;  // -0 < +0 is false here
      RDN:     cmp_bit = (mag_eq & (sign_a == sign_b)) | both_zero;
      default: cmp_bit = 1'b0;
    endcase
  end

  assign class_mask[0] = sign_a & a_class_i[CLASS_INF];
  assign class_mask[1] = sign_a & a_class_i[CLASS_NORMAL];
  assign class_mask[2] = sign_a & a_class_i[CLASS_SUB];
  assign class_mask[3] = sign_a & a_class_i[CLASS_ZERO];
  assign class_mask[4] = ~sign_a & a_class_i[CLASS_ZERO];
  assign class_mask[5] = ~sign_a & a_class_i[CLASS_SUB];
  assign class_mask[6] = ~sign_a & a_class_i[CLASS_NORMAL];
  assign class_mask[7] = ~sign_a & a_class_i[CLASS_INF];
  assign class_mask[8] = a_class_i[CLASS_SNAN];
  assign class_mask[9] = a_class_i[CLASS_NAN] & ~a_class_i[CLASS_SNAN];

  always_comb begin
    result_d = '0;
    nv_d     = 1'b0;
    case (op_i)
      SGNJ: begin
        result_d = {inj_sign, op_a_i[`FPU_WIDTH-2:0]};
      end
      MINMAX: begin
        nv_d = any_snan;
        if (a_class_i[CLASS_NAN] && b_class_i[CLASS_NAN]) begin
          result_d = `FPU_CANON_NAN;
        end else if (a_class_i[CLASS_NAN]) begin
          result_d = op_b_i;
        end else if (b_class_i[CLASS_NAN]) begin
          result_d = op_a_i;
        end else if (rnd_mode_i == RTZ) begin
          result_d = a_lt_b ? op_b_i : op_a_i;  // Max
        end else begin
          result_d = a_lt_b ? op_a_i : op_b_i;  // Min
        end
      end
      CMP: begin
        result_d[0] = cmp_bit & ~any_nan;
        nv_d        = (rnd_mode_i == RDN) ? any_snan : any_nan;  // Quiet EQ, signaling LT/LE
      end
      default: begin
        result_d[9:0] = class_mask;
      end
    endcase
    status_d            = '0;
    status_d[STATUS_NV] = nv_d;
  end

  assign ready_o = ~valid_q | ready_i;
  assign valid_o = valid_q;
  assign load    = valid_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      result_o <= result_d;
      status_o <= status_d;
      tag_o    <= tag_i;
    end
  end

  a_only_nv: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o |-> !(status_o[STATUS_DZ] | status_o[STATUS_OF] | status_o[STATUS_UF]
                  | status_o[STATUS_NX]));

  a_class_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    load && op_i == CLASSIFY |=> $onehot(result_o[9:0]) && result_o[`FPU_WIDTH-1:10] == '0);

endmodule

`default_nettype wire

// File: source/fpu_top.sv
// FP64 non-arithmetic FPU; results leave in request order through a four-stage pipeline
`timescale 1ns/1ns
`include "fpu_macros.svh"
`default_nettype none

module fpu_top import fpu_pkg::*; (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic [`FPU_WIDTH-1:0]        operands_a_i,
  input  logic [`FPU_WIDTH-1:0]        operands_b_i,
  input  fpu_op_e                      op_i,
  input  roundmode_e                   rnd_mode_i,
  input  logic [`FPU_TAG_WIDTH-1:0]    tag_i,
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  output logic [`FPU_WIDTH-1:0]        result_o,
  output logic [`FPU_STATUS_WIDTH-1:0] status_o,
  output logic [`FPU_TAG_WIDTH-1:0]    tag_o,
  output logic                         out_valid_o,
  input  logic                         out_ready_i
);

  localparam int unsigned REQ_WIDTH = 2 * `FPU_WIDTH + $bits(fpu_op_e) + $bits(roundmode_e)
                                      + `FPU_TAG_WIDTH;
  localparam int unsigned RSP_WIDTH = `FPU_WIDTH + `FPU_STATUS_WIDTH + `FPU_TAG_WIDTH;

  logic [REQ_WIDTH-1:0]           req, req_q;
  logic                           req_valid_q, req_ready_q;
  logic [`FPU_WIDTH-1:0]          req_a, req_b;
  logic [$bits(fpu_op_e)-1:0]     req_op;
  logic [$bits(roundmode_e)-1:0]  req_rnd;
  logic [`FPU_TAG_WIDTH-1:0]      req_tag;

  logic                           cls_valid, cls_ready;
  logic [`FPU_WIDTH-1:0]          cls_a, cls_b;
  fpu_op_e                        cls_op;
  roundmode_e                     cls_rnd;
  logic [`FPU_TAG_WIDTH-1:0]      cls_tag;
  logic [`FPU_CLASS_WIDTH-1:0]    cls_a_class, cls_b_class;

  logic                           rsp_valid, rsp_ready;
  logic [`FPU_WIDTH-1:0]          rsp_result;
  logic [`FPU_STATUS_WIDTH-1:0]   rsp_status;
  logic [`FPU_TAG_WIDTH-1:0]      rsp_tag;
  logic [RSP_WIDTH-1:0]           rsp, rsp_q;

  assign req = {operands_a_i, operands_b_i, op_i, rnd_mode_i, tag_i};
  assign {req_a, req_b, req_op, req_rnd, req_tag} = req_q;

  spill_register #(
    .WIDTH ( REQ_WIDTH )
  ) i_spill_in (
    .clk_i   ( clk_i       ),
    .reset_i ( reset_i     ),
    .valid_i ( in_valid_i  ),
    .ready_o ( in_ready_o  ),
    .data_i  ( req         ),
    .valid_o ( req_valid_q ),
    .ready_i ( req_ready_q ),
    .data_o  ( req_q       )
  );

  fp_classify_stage i_classify (
    .clk_i      ( clk_i                 ),
    .reset_i    ( reset_i               ),
    .valid_i    ( req_valid_q           ),
    .ready_o    ( req_ready_q           ),
    .op_a_i     ( req_a                 ),
    .op_b_i     ( req_b                 ),
    .op_i       ( fpu_op_e'(req_op)     ),
    .rnd_mode_i ( roundmode_e'(req_rnd) ),
    .tag_i      ( req_tag               ),
    .valid_o    ( cls_valid             ),
    .ready_i    ( cls_ready             ),
    .op_a_o     ( cls_a                 ),
    .op_b_o     ( cls_b                 ),
    .op_o       ( cls_op                ),
    .rnd_mode_o ( cls_rnd               ),
    .tag_o      ( cls_tag               ),
    .a_class_o  ( cls_a_class           ),
    .b_class_o  ( cls_b_class           )
  );

  fp_noncomp_stage i_noncomp (
    .clk_i      ( clk_i       ),
    .reset_i    ( reset_i     ),
    .valid_i    ( cls_valid   ),
    .ready_o    ( cls_ready   ),
    .op_a_i     ( cls_a       ),
    .op_b_i     ( cls_b       ),
    .op_i       ( cls_op      ),
    .rnd_mode_i ( cls_rnd     ),
    .tag_i      ( cls_tag     ),
    .a_class_i  ( cls_a_class ),
    .b_class_i  ( cls_b_class ),
    .valid_o    ( rsp_valid   ),
    .ready_i    ( rsp_ready   ),
    .result_o   ( rsp_result  ),
    .status_o   ( rsp_status  ),
    .tag_o      ( rsp_tag     )
  );

  assign rsp = {rsp_result, rsp_status, rsp_tag};

  spill_register #(
    .WIDTH ( RSP_WIDTH )
  ) i_spill_out (
    .clk_i   ( clk_i       ),
    .reset_i ( reset_i     ),
    .valid_i ( rsp_valid   ),
    .ready_o ( rsp_ready   ),
    .data_i  ( rsp         ),
    .valid_o ( out_valid_o ),
    .ready_i ( out_ready_i ),
    .data_o  ( rsp_q       )
  );

  assign {result_o, status_o, tag_o} = rsp_q;

endmodule

`default_nettype wire

// File: test/tb_clock.sv
// Free-running clock from time zero; reset is released on a rising edge after RESET_CYCLES
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int unsigned PERIOD_NS    = 8,
  parameter int unsigned RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    reset_o <= 1'b0;  // Sampled high on every reset edge
  end

endmodule

`default_nettype wire

// File: test/fpu_tb.sv
// Needs --assert for the checks; the reference model knows only the modes each operation uses
`timescale 1ns/1ns
`include "fpu_macros.svh"
`default_nettype none

module fpu_tb import fpu_pkg::*; ();

  localparam int unsigned PERIOD_NS = 8;
  localparam int unsigned N_SPECIAL = 12;
  localparam int unsigned N_SGNJ    = 40;
  localparam int unsigned N_CLASS   = 20;
  localparam int unsigned N_STRESS  = 100;
  localparam int unsigned N_TOTAL   = 3 * N_SGNJ + 5 * N_SPECIAL * N_SPECIAL + N_SPECIAL
                                      + N_CLASS + N_STRESS + 1;
  localparam longint unsigned WATCHDOG_NS = (N_TOTAL * 20 + 500) * PERIOD_NS;

  logic                         clk, reset;
  logic [`FPU_WIDTH-1:0]        operands_a, operands_b, result;
  fpu_op_e                      op;
  roundmode_e                   rnd_mode;
  logic [`FPU_TAG_WIDTH-1:0]    tag, tag_out;
  logic                         in_valid, in_ready, out_valid, out_ready;
  logic [`FPU_STATUS_WIDTH-1:0] status;

  logic [31:0] lfsr_state;
  logic [`FPU_WIDTH+`FPU_STATUS_WIDTH+`FPU_TAG_WIDTH-1:0] exp_q [$];  // {result, status, tag}
  logic [`FPU_WIDTH-1:0]        head_result;
  logic [`FPU_STATUS_WIDTH-1:0] head_status;
  logic [`FPU_TAG_WIDTH-1:0]    head_tag;
  logic head_avail, idle_check, random_ready;
  int errors, sent, checked, tests, test_errors, test_sent;

  tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(3)) i_clock (.clk_o(clk), .reset_o(reset));

  fpu_top dut_i (
    .clk_i        ( clk        ),
    .reset_i      ( reset      ),
    .operands_a_i ( operands_a ),
    .operands_b_i ( operands_b ),
    .op_i         ( op         ),
    .rnd_mode_i   ( rnd_mode   ),
    .tag_i        ( tag        ),
    .in_valid_i   ( in_valid   ),
    .in_ready_o   ( in_ready   ),
    .result_o     ( result     ),
    .status_o     ( status     ),
    .tag_o        ( tag_out    ),
    .out_valid_o  ( out_valid  ),
    .out_ready_i  ( out_ready  )
  );

  // Taps 32, 22, 2, 1
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    logic        fb;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v          = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic logic [`FPU_WIDTH-1:0] special_value(input int idx);
    case (idx)
      0:       return 64'h0000000000000000;  // +0
      1:       return 64'h8000000000000000;
      2:       return 64'h7ff0000000000000;  // +inf
      3:       return 64'hfff0000000000000;
      4:       return 64'h7ff8000000000000;  // Quiet NaNs
      5:       return 64'hfff8000000000001;
      6:       return 64'h7ff0000000000001;  // Signaling NaNs
      7:       return 64'hfff4000000000000;
      8:       return 64'h0000000000000001;  // Subnormals
      9:       return 64'h800fffffffffffff;
      10:      return 64'h3ff0000000000000;  // 1.0
      default: return 64'hc000000000000000;  // -2.0
    endcase
  endfunction

  function automatic logic [`FPU_WIDTH-1:0] pick_operand();
    logic [63:0] idx;
    idx = take_bits(4);
    if (idx < N_SPECIAL) begin
      return special_value(int'(idx));
    end
    return take_bits(64);
  endfunction

  function automatic logic nan_value(input logic [63:0] x);
    return x[62:52] == 11'h7ff && x[51:0] != '0;
  endfunction

  // Orders -0 below +0; both operands must be numbers
  function automatic logic ordered_less(input logic [63:0] a, input logic [63:0] b);
    if (a[63] != b[63]) begin
      return a[63];
    end
    return a[63] ? (a[62:0] > b[62:0]) : (a[62:0] < b[62:0]);
  endfunction

  function automatic int class_index(input logic [63:0] x);
    if (x[62:52] == 11'h7ff) begin
      return (x[51:0] == '0) ? (x[63] ? 0 : 7) : (x[51] ? 9 : 8);
    end else if (x[62:52] == '0) begin
      return (x[51:0] == '0) ? (x[63] ? 3 : 4) : (x[63] ? 2 : 5);
    end
    return x[63] ? 1 : 6;
  endfunction

  // Returns {result, status}
  function automatic logic [68:0] expected_response(input logic [63:0] a, input logic [63:0] b,
                                                    input fpu_op_e o, input roundmode_e rm);
    logic [63:0] res;
    logic [4:0]  st;
    logic        a_nan, b_nan, snan, zeros, eq, lt;
    res   = '0;
    st    = '0;
    a_nan = nan_value(a);
    b_nan = nan_value(b);
    snan  = (a_nan && !a[51]) || (b_nan && !b[51]);
    zeros = a[62:0] == '0 && b[62:0] == '0;
    case (o)
      SGNJ: begin
        res = {(rm == RTZ) ? !b[63] : (rm == RDN) ? a[63] ^ b[63] : b[63], a[62:0]};
      end
      MINMAX: begin
        st[STATUS_NV] = snan;
        if (a_nan && b_nan) res = `FPU_CANON_NAN;
        else if (a_nan) res = b;
        else if (b_nan) res = a;
        else res = (ordered_less(a, b) != (rm == RTZ)) ? a : b;
      end
      CMP: begin
        eq = zeros || a == b;
        lt = ordered_less(a, b) && !zeros;
        st[STATUS_NV] = (rm == RDN) ? snan : (a_nan || b_nan);
        res[0] = !(a_nan || b_nan) && ((rm == RDN) ? eq : (rm == RTZ) ? lt : (lt || eq));
      end
      default: begin
        res[class_index(a)] = 1'b1;
      end
    endcase
    return {res, st};
  endfunction

  task automatic refresh_head();
    head_avail = exp_q.size() != 0;
    {head_result, head_status, head_tag} = head_avail ? exp_q[0] : '0;
  endtask

  task automatic show_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
    $display("mismatch %s: got %h, expected %h at %0t ns", name, got, expected, $time);
    errors++;
  endtask

  task automatic record_failure(input string msg);
    $display("error: %s at %0t ns", msg, $time);
    errors++;
  endtask

  task automatic drive_out_ready();
    out_ready = random_ready ? take_bits(1) != 0 : 1'b1;
  endtask

  // Called on a falling edge; in_ready depends only on registered state
  task automatic send_request(input logic [63:0] a, input logic [63:0] b, input fpu_op_e o,
                              input roundmode_e rm);
    operands_a = a;
    operands_b = b;
    op         = o;
    rnd_mode   = rm;
    in_valid   = 1'b1;
    drive_out_ready();
    while (!in_ready) begin
      @(negedge clk);
      drive_out_ready();
    end
    exp_q.push_back({expected_response(a, b, o, rm), tag});
    refresh_head();
    sent++;
    @(negedge clk);
    tag++;
    in_valid = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 200) begin
      drive_out_ready();
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) record_failure("results still outstanding after drain timeout");
  endtask

  task automatic open_test();
    test_errors = errors;
    test_sent   = sent;
  endtask

  task automatic close_test(input string name);
    drain();
    $display("test %-14s %4d requests, %0d errors", name, sent - test_sent, errors - test_errors);
    tests++;
  endtask

  a_no_extra: assert property (@(posedge clk) disable iff (reset)
    out_valid && out_ready |-> head_avail)
    else record_failure("output accepted with no request outstanding");
  a_result: assert property (@(posedge clk) disable iff (reset)
    out_valid && out_ready && head_avail |-> result == head_result)
    else show_mismatch("result_o", $sampled(result), $sampled(head_result));
  a_status: assert property (@(posedge clk) disable iff (reset)
    out_valid && out_ready && head_avail |-> status == head_status)
    else show_mismatch("status_o", $sampled(status), $sampled(head_status));
  a_tag: assert property (@(posedge clk) disable iff (reset)
    out_valid && out_ready && head_avail |-> tag_out == head_tag)
    else show_mismatch("tag_o", $sampled(tag_out), $sampled(head_tag));
  a_hold: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(result) && $stable(status)
                                && $stable(tag_out))
    else record_failure("output dropped or changed while stalled");
  a_idle: assert property (@(posedge clk) disable iff (reset)
    idle_check |-> !out_valid && in_ready)
    else record_failure("output valid or input not ready while idle after reset");

  always @(posedge clk) begin
    if (!reset && out_valid && out_ready && head_avail) begin
      void'(exp_q.pop_front());
      checked++;
      refresh_head();
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests completed");
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    int          i, j, k, cycles;
    logic [63:0] a, b, sel;
    fpu_op_e     o;
    roundmode_e  rm;
    lfsr_state   = 32'hd258;
    operands_a   = '0;
    operands_b   = '0;
    op           = SGNJ;
    rnd_mode     = RNE;
    tag          = '0;
    in_valid     = 1'b0;
    out_ready    = 1'b1;
    idle_check   = 1'b0;
    random_ready = 1'b0;
    refresh_head();
    @(negedge clk);
    while (reset) @(negedge clk);

    open_test();
    idle_check = 1'b1;
    repeat (8) @(negedge clk);
    idle_check = 1'b0;
    send_request(special_value(10), special_value(11), MINMAX, RNE);
    cycles = 1;  // Acceptance edge counts
    while (!out_valid && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    assert (cycles == 4) else show_mismatch("out_valid_o latency", cycles, 4);
    close_test("reset_latency");

    open_test();
    for (k = 0; k < 3; k++) begin
      for (i = 0; i < N_SGNJ; i++) begin
        a = pick_operand();
        b = pick_operand();
        send_request(a, b, SGNJ, roundmode_e'(k));
      end
    end
    close_test("sign_inject");

    open_test();
    for (k = 0; k < 5; k++) begin  // Two min/max modes, then three compare modes
      for (i = 0; i < N_SPECIAL; i++) begin
        for (j = 0; j < N_SPECIAL; j++) begin
          send_request(special_value(i), special_value(j), (k < 2) ? MINMAX : CMP,
                       roundmode_e'((k < 2) ? k : k - 2));
        end
      end
      if (k == 1) close_test("min_max");
      if (k == 1) open_test();
    end
    close_test("compare");

    open_test();
    for (i = 0; i < N_SPECIAL + N_CLASS; i++) begin
      a = (i < N_SPECIAL) ? special_value(i) : pick_operand();
      send_request(a, '0, CLASSIFY, RNE);
    end
    close_test("classify");

    open_test();
    random_ready = 1'b1;
    for (i = 0; i < N_STRESS; i++) begin
      sel = take_bits(2);
      o   = fpu_op_e'(sel[1:0]);
      rm  = (o == MINMAX) ? (take_bits(1) != 0 ? RTZ : RNE) :
            (o == CLASSIFY) ? RNE : roundmode_e'(int'(take_bits(2)) % 3);
      a   = pick_operand();
      b   = pick_operand();
      send_request(a, b, o, rm);
    end
    close_test("backpressure");
    random_ready = 1'b0;

    assert (exp_q.size() == 0) else record_failure("requests lost in the pipeline");
    $display("%0d tests, %0d requests, %0d results checked, %0d errors",
             tests, sent, checked, errors);
    if (errors == 0 && checked == sent) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+source
source/fpu_pkg.sv
source/spill_register.sv
source/fp_classify_stage.sv
source/fp_noncomp_stage.sv
source/fpu_top.sv
test/tb_clock.sv
test/fpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the FPU testbench with Verilator and runs it; exits non-zero unless the run passes

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module fpu_tb -o fpu_sim &&
./obj_dir/fpu_sim | tee /dev/stderr | grep -qF '*** PASSED ***' &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }
